// ==== hdl/front_end_pkg.sv ====
package front_end_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] inst_t;

	// x0 is hardwired, used when a slot has no register
	localparam logic [4:0] zero_reg = 5'd0;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// rv32i major opcodes, bits [6:0] of the word
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_PC,
		OPA_IS_ZERO
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_sel_e;

	// one decoded slot as handed to dispatch
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] npc;
		inst_t           inst;
		alu_func_e       alu_func;
		opa_sel_e        opa_select;
		opb_sel_e        opb_select;
		logic [4:0]      dest_reg_idx;
		logic [1:0][4:0] src_reg_idx;
		logic [1:0]      src_req;
		logic            rd_mem;
		logic            wr_mem;
		logic            cond_branch;
		logic            uncond_branch;
		logic            halt;
		logic            illegal;
	} decoded_inst_t;

endpackage

// ==== hdl/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;
	import front_end_pkg::*;

	// doubleword aligned fetch address
	logic [XLEN-1:0] address;
	logic            request;
	// line from the buffer, low word at the lower address
	logic [63:0]     doubleword;
	logic            data_valid;

	modport requester (
		output address,
		output request,
		input  doubleword,
		input  data_valid
	);

	modport server (
		input  address,
		input  request,
		output doubleword,
		output data_valid
	);

endinterface

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input  logic                     slot_enable,
	input  front_end_pkg::inst_t     inst,
	output logic                     valid_inst,
	output front_end_pkg::alu_func_e alu_func,
	output front_end_pkg::opa_sel_e  opa_select,
	output front_end_pkg::opb_sel_e  opb_select,
	output logic [4:0]               dest_reg_idx,
	output logic [4:0]               src_reg_idx_0,
	output logic [4:0]               src_reg_idx_1,
	output logic                     src_req_0,
	output logic                     src_req_1,
	output logic                     rd_mem,
	output logic                     wr_mem,
	output logic                     cond_branch,
	output logic                     uncond_branch,
	output logic                     halt,
	output logic                     illegal
);
	import front_end_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       has_dest;

	// funct3 to alu op, alt picks sub / sra
	function automatic alu_func_e alu_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		alu_func      = ALU_ADD;
		opa_select    = OPA_IS_RS1;
		opb_select    = OPB_IS_RS2;
		has_dest      = 1'b0;
		src_req_0     = 1'b0;
		src_req_1     = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (slot_enable) begin
			case (opcode)
				OPC_LUI: begin
					has_dest   = 1'b1;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_U_IMM;
				end
				OPC_AUIPC: begin
					has_dest   = 1'b1;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_U_IMM;
				end
				OPC_JAL: begin
					has_dest      = 1'b1;
					opa_select    = OPA_IS_PC;
					opb_select    = OPB_IS_J_IMM;
					uncond_branch = 1'b1;
				end
				OPC_JALR: begin
					has_dest      = 1'b1;
					src_req_0     = 1'b1;
					opb_select    = OPB_IS_I_IMM;
					uncond_branch = 1'b1;
					illegal       = (funct3 != 3'b000);
				end
				OPC_BRANCH: begin
					src_req_0   = 1'b1;
					src_req_1   = 1'b1;
					opa_select  = OPA_IS_PC;
					opb_select  = OPB_IS_B_IMM;
					cond_branch = 1'b1;
					illegal     = (funct3 inside {3'b010, 3'b011});
				end
				OPC_LOAD: begin
					has_dest   = 1'b1;
					src_req_0  = 1'b1;
					opb_select = OPB_IS_I_IMM;
					rd_mem     = 1'b1;
					illegal    = (funct3 inside {3'b011, 3'b110, 3'b111});
				end
				OPC_STORE: begin
					src_req_0  = 1'b1;
					src_req_1  = 1'b1;
					opb_select = OPB_IS_S_IMM;
					wr_mem     = 1'b1;
					illegal    = (funct3 > 3'b010);
				end
				OPC_OP_IMM: begin
					has_dest   = 1'b1;
					src_req_0  = 1'b1;
					opb_select = OPB_IS_I_IMM;
					// addi has no sub form, only the shifts look at bit 30
					alu_func   = alu_op(funct3, funct3 == 3'b101 && inst[30]);
					if (funct3 == 3'b001) begin
						illegal = (funct7 != 7'b0000000);
					end else if (funct3 == 3'b101) begin
						illegal = !(funct7 inside {7'b0000000, 7'b0100000});
					end
				end
				OPC_OP: begin
					has_dest  = 1'b1;
					src_req_0 = 1'b1;
					src_req_1 = 1'b1;
					alu_func  = alu_op(funct3, inst[30]);
					illegal   = !(funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}));
				end
				OPC_SYSTEM: begin
					// only ecall and ebreak, no csr support here
					src_req_0 = 1'b1;
					halt      = (inst == 32'h0000_0073) || (inst == 32'h0010_0073);
					illegal   = !halt;
				end
				default: begin
					illegal = 1'b1;
				end
			endcase
		end
	end

	assign valid_inst    = slot_enable && !illegal;
	assign dest_reg_idx  = has_dest ? inst[11:7] : zero_reg;
	assign src_reg_idx_0 = src_req_0 ? inst[19:15] : zero_reg;
	assign src_reg_idx_1 = src_req_1 ? inst[24:20] : zero_reg;

endmodule

// ==== hdl/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage #(
	parameter logic [front_end_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             squash,
	input  logic [front_end_pkg::XLEN-1:0]   squash_target,
	input  logic                             dispatch_ready_0,
	input  logic                             dispatch_ready_1,
	fetch_if.requester                       fetch,
	output front_end_pkg::decoded_inst_t     slot_0,
	output front_end_pkg::decoded_inst_t     slot_1
);
	import front_end_pkg::*;

	logic [XLEN-1:0] pc_reg;
	decoded_inst_t   pkt [2];
	logic [1:0]      valid_inst;
	logic            take_0;
	logic            take_1;

	////////////////////////////////////////
	// fetch request
	////////////////////////////////////////

	assign fetch.address = {pc_reg[XLEN-1:3], 3'b000};
	// the old line is of no use in a squash cycle
	assign fetch.request = !squash;

	////////////////////////////////////////
	// slot split and decode
	////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : gen_slot
		logic enable;

		// slot 1 is the upper word, so it only exists from a lower-word pc
		assign enable = (i == 0) ? fetch.data_valid : fetch.data_valid && !pc_reg[2];

		assign pkt[i].inst = (i == 0 && !pc_reg[2]) ? fetch.doubleword[31:0]
		                                             : fetch.doubleword[63:32];
		assign pkt[i].pc   = pc_reg + XLEN'(4 * i);
		assign pkt[i].npc  = pc_reg + XLEN'(4 * (i + 1));

		// illegal words still go down so the rob can trap on them
		assign pkt[i].valid = valid_inst[i] || pkt[i].illegal;

		inst_decoder u_decoder (
			.slot_enable   (enable),
			.inst          (pkt[i].inst),
			.valid_inst    (valid_inst[i]),
			.alu_func      (pkt[i].alu_func),
			.opa_select    (pkt[i].opa_select),
			.opb_select    (pkt[i].opb_select),
			.dest_reg_idx  (pkt[i].dest_reg_idx),
			.src_reg_idx_0 (pkt[i].src_reg_idx[0]),
			.src_reg_idx_1 (pkt[i].src_reg_idx[1]),
			.src_req_0     (pkt[i].src_req[0]),
			.src_req_1     (pkt[i].src_req[1]),
			.rd_mem        (pkt[i].rd_mem),
			.wr_mem        (pkt[i].wr_mem),
			.cond_branch   (pkt[i].cond_branch),
			.uncond_branch (pkt[i].uncond_branch),
			.halt          (pkt[i].halt),
			.illegal       (pkt[i].illegal)
		);
	end

	assign slot_0 = pkt[0];
	assign slot_1 = pkt[1];

	////////////////////////////////////////
	// pc advance
	////////////////////////////////////////

	// slot 1 can only go together with slot 0
	assign take_0 = pkt[0].valid && dispatch_ready_0;
	assign take_1 = take_0 && pkt[1].valid && dispatch_ready_1;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= RESET_PC;
		end else if (squash) begin
			pc_reg <= squash_target;
		end else if (take_0) begin
			pc_reg <= take_1 ? pkt[1].npc : pkt[0].npc;
		end
	end

	// slot 1 valid without slot 0 would break in-order dispatch
	a_slot_order: assert property (@(posedge clock) disable iff (reset)
		slot_1.valid |-> slot_0.valid);

	// squash targets from the rob must keep the pc on a word
	a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
		pc_reg[1:0] == 2'b00);

endmodule

// ==== hdl/imem_fetch_unit.sv ====
`timescale 1ns/1ps

module imem_fetch_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [63:0]                    wb_dat_in,
	input  logic                           wb_ack,
	fetch_if.server                        fetch,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic [front_end_pkg::XLEN-1:0] wb_adr
);
	import front_end_pkg::*;

	typedef enum logic {IDLE, BUSY} state_e;

	state_e          state;
	logic [63:0]     line_data;
	logic [XLEN-1:0] line_tag;
	logic            line_tag_valid;
	logic            hit;
	logic            start_read;

	// one line buffer, hit only against the current address
	assign hit               = line_tag_valid && (line_tag == fetch.address);
	assign fetch.doubleword  = line_data;
	assign fetch.data_valid  = fetch.request && hit;

	assign start_read = (state == IDLE) && fetch.request && !hit;

	assign wb_cyc = (state == BUSY);
	assign wb_stb = (state == BUSY);

	always_ff @(posedge clock) begin
		if (reset) begin
			state          <= IDLE;
			line_tag_valid <= 1'b0;
		end else if (start_read) begin
			state <= BUSY;
		end else if (state == BUSY && wb_ack) begin
			state          <= IDLE;
			line_tag_valid <= 1'b1;
		end
	end

	// stale lines land under the address they were read from
	always_ff @(posedge clock) begin
		if (start_read) begin
			wb_adr <= fetch.address;
		end
		if (state == BUSY && wb_ack) begin
			line_data <= wb_dat_in;
			line_tag  <= wb_adr;
		end
	end

	a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_stb |-> wb_cyc);

	// classic cycle holds stb and the address until ack
	a_adr_held: assert property (@(posedge clock) disable iff (reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// ==== hdl/front_end_top.sv ====
`timescale 1ns/1ps

module front_end_top #(
	parameter logic [front_end_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           squash,
	input  logic [front_end_pkg::XLEN-1:0] squash_target,
	input  logic                           dispatch_ready_0,
	input  logic                           dispatch_ready_1,
	input  logic [63:0]                    wb_dat_in,
	input  logic                           wb_ack,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic [front_end_pkg::XLEN-1:0] wb_adr,
	output front_end_pkg::decoded_inst_t   slot_0,
	output front_end_pkg::decoded_inst_t   slot_1
);

	// request / line path between pc owner and bus master
	fetch_if fetch_bus ();

	dispatch_stage #(
		.RESET_PC (RESET_PC)
	) u_dispatch (
		.clock            (clock),
		.reset            (reset),
		.squash           (squash),
		.squash_target    (squash_target),
		.dispatch_ready_0 (dispatch_ready_0),
		.dispatch_ready_1 (dispatch_ready_1),
		.fetch            (fetch_bus.requester),
		.slot_0           (slot_0),
		.slot_1           (slot_1)
	);

	imem_fetch_unit u_fetch (
		.clock     (clock),
		.reset     (reset),
		.wb_dat_in (wb_dat_in),
		.wb_ack    (wb_ack),
		.fetch     (fetch_bus.server),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_adr    (wb_adr)
	);

endmodule

// ==== testbench/tb_front_end.sv ====
`timescale 1ns/1ps

module tb_front_end;
	import front_end_pkg::*;

	logic          clock;
	logic          reset;
	logic          squash;
	logic [31:0]   squash_target;
	logic          dispatch_ready_0;
	logic          dispatch_ready_1;
	logic [63:0]   wb_dat_in;
	logic          wb_ack;
	logic          wb_cyc;
	logic          wb_stb;
	logic [31:0]   wb_adr;
	decoded_inst_t slot_0;
	decoded_inst_t slot_1;

	logic [31:0] mem [0:255];
	string       exp_name [0:63];
	logic [31:0] exp_field [0:63][0:8];
	int          sq_after [0:15];
	logic [31:0] sq_target [0:15];
	int          n_exp = 0;
	int          n_sq = 0;
	int          sq_idx = 0;
	int          checked = 0;
	int          edge_count = 0;
	int          ack_wait = -1;
	logic [31:0] rng = 32'hf6df_291f;
	logic        prev_stb = 1'b0;
	logic        prev_ack = 1'b0;
	logic        loaded = 1'b0;
	logic        sq_hold = 1'b0;

	front_end_top #(.RESET_PC(32'h0)) uut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("ERROR %s %s expected %h actual %h", test, field, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch on a dispatched packet");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("CHECKS FAILED");
			$fatal(1, "protocol check");
		end
	endtask

	// compare one taken packet with the next expected line
	task automatic compare_slot(input decoded_inst_t s);
		check_true(checked < n_exp, "a packet was taken beyond the expected list");
		check_value(exp_name[checked], "pc", exp_field[checked][0], s.pc);
		// each packet's next pc is the following word
		check_value(exp_name[checked], "npc", exp_field[checked][0] + 32'd4, s.npc);
		check_value(exp_name[checked], "inst", exp_field[checked][1], s.inst);
		check_value(exp_name[checked], "rd", exp_field[checked][2], 32'(s.dest_reg_idx));
		check_value(exp_name[checked], "rs1", exp_field[checked][3], 32'(s.src_reg_idx[0]));
		check_value(exp_name[checked], "rs2", exp_field[checked][4], 32'(s.src_reg_idx[1]));
		check_value(exp_name[checked], "req0", exp_field[checked][5], 32'(s.src_req[0]));
		check_value(exp_name[checked], "req1", exp_field[checked][6], 32'(s.src_req[1]));
		check_value(exp_name[checked], "alu", exp_field[checked][7], 32'(s.alu_func));
		check_value(exp_name[checked], "illegal", exp_field[checked][8], 32'(s.illegal));
		checked++;
	endtask

	////////////////////////////////////////
	// test file
	////////////////////////////////////////

	initial begin
		int          fd;
		string       line;
		string       kind;
		string       name;
		logic [31:0] v [0:8];
		int          n;
		reset = 1'b1;
		squash = 1'b0;
		squash_target = 32'h0;
		dispatch_ready_0 = 1'b0;
		dispatch_ready_1 = 1'b0;
		wb_dat_in = 64'h0;
		wb_ack = 1'b0;
		// unused words still differ by address
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hcafe_0000 | 32'(i << 2);
		end
		fd = $fopen("testbench/front_end_tests.txt", "r");
		check_true(fd != 0, "could not open the test file");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			kind = "";
			n = $sscanf(line, "%s", kind);
			if (kind == "m") begin
				n = $sscanf(line, "%s %h %h", kind, v[0], v[1]);
				mem[v[0][9:2]] = v[1];
			end else if (kind == "s") begin
				n = $sscanf(line, "%s %d %h", kind, sq_after[n_sq], sq_target[n_sq]);
				n_sq++;
			end else if (kind == "e") begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", kind, name,
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
				exp_name[n_exp] = name;
				for (int k = 0; k < 9; k++) begin
					exp_field[n_exp][k] = v[k];
				end
				n_exp++;
			end
		end
		$fclose(fd);
		loaded = 1'b1;
	end

	// watchdog, 200 cycles per expected packet
	initial begin
		wait (loaded);
		repeat (200 * n_exp + 20) @(posedge clock);
		$display("timeout: the expected packets were not all dispatched in time");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog");
	end

	////////////////////////////////////////
	// memory, drivers and checker
	////////////////////////////////////////

	always @(posedge clock) begin
		logic pending;
		if (edge_count >= 1 && edge_count <= 4) begin
			check_true(!wb_cyc && !slot_0.valid && !slot_1.valid,
				"bus or slot active during or right after reset");
		end
		if (edge_count == 3) begin
			reset <= 1'b0;
		end
		if (edge_count >= 4) begin
			if (wb_cyc) begin
				check_true(wb_adr[2:0] == 3'b000, "bus address not doubleword aligned");
			end
			if (prev_stb && !prev_ack) begin
				check_true(wb_stb, "stb dropped before ack");
			end
			if (slot_0.valid && slot_0.pc[2]) begin
				check_true(!slot_1.valid, "slot 1 valid from an upper-word pc");
			end
			prev_stb = wb_stb;
			prev_ack = wb_ack;

			// takes as the DUT sees them on this edge
			if (!squash && slot_0.valid && dispatch_ready_0) begin
				compare_slot(slot_0);
				if (slot_1.valid && dispatch_ready_1) begin
					compare_slot(slot_1);
				end
			end

			// wishbone slave with a random ack delay
			if (wb_ack) begin
				wb_ack <= 1'b0;
			end else if (wb_stb) begin
				if (ack_wait < 0) begin
					rng = xorshift(rng);
					ack_wait = int'(rng[1:0]);
				end
				if (ack_wait == 0) begin
					wb_ack <= 1'b1;
					wb_dat_in <= {mem[{wb_adr[9:3], 1'b1}], mem[{wb_adr[9:3], 1'b0}]};
					ack_wait = -1;
				end else begin
					ack_wait--;
				end
			end

			if (squash) begin
				sq_idx++;
			end
			pending = sq_idx < n_sq;
			rng = xorshift(rng);
			if (!squash && pending && checked == sq_after[sq_idx]) begin
				// a quiet cycle lets the next line read start before the squash
				if (sq_hold) begin
					squash <= 1'b1;
					squash_target <= sq_target[sq_idx];
					sq_hold = 1'b0;
				end else begin
					squash <= 1'b0;
					sq_hold = 1'b1;
				end
				dispatch_ready_0 <= 1'b0;
				dispatch_ready_1 <= 1'b0;
			end else begin
				squash <= 1'b0;
				dispatch_ready_0 <= rng[0] | rng[1];
				// keep slot 1 back so the squash point is hit exactly
				dispatch_ready_1 <= rng[2] && !(pending && checked == sq_after[sq_idx] - 1);
			end
		end
		edge_count++;
		if (loaded && checked == n_exp) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== testbench/front_end_tests.txt ====
# m byte_address word
# s taken_count squash_target
# e name pc inst rd rs1 rs2 req0 req1 alu illegal
m 00000000 123450b7
m 00000004 00001117
m 00000008 00508193
m 0000000c 00208233
m 00000010 403202b3
m 00000014 4022d313
m 00000018 00812383
m 0000001c 00712623
m 00000020 00208463
m 00000024 000000ef
m 00000028 00008067
m 0000002c ffffffff
m 00000030 0020c433
m 00000044 0020e4b3
m 00000048 0020a533
m 0000004c 00000073
m 00000080 0ff0f593
m 00000084 0010b613
m 00000088 0030d693
m 0000008c 00109713
s 13 00000044
s 16 00000080
e lui    00000000 123450b7 1 0 0 0 0 0 0
e auipc  00000004 00001117 2 0 0 0 0 0 0
e addi   00000008 00508193 3 1 0 1 0 0 0
e add    0000000c 00208233 4 1 2 1 1 0 0
e sub    00000010 403202b3 5 4 3 1 1 1 0
e srai   00000014 4022d313 6 5 0 1 0 9 0
e lw     00000018 00812383 7 2 0 1 0 0 0
e sw     0000001c 00712623 0 2 7 1 1 0 0
e beq    00000020 00208463 0 1 2 1 1 0 0
e jal    00000024 000000ef 1 0 0 0 0 0 0
e jalr   00000028 00008067 0 1 0 1 0 0 0
e bad    0000002c ffffffff 0 0 0 0 0 0 1
e xor    00000030 0020c433 8 1 2 1 1 6 0
e or     00000044 0020e4b3 9 1 2 1 1 5 0
e slt    00000048 0020a533 a 1 2 1 1 2 0
e ecall  0000004c 00000073 0 0 0 1 0 0 0
e andi   00000080 0ff0f593 b 1 0 1 0 4 0
e sltiu  00000084 0010b613 c 1 0 1 0 3 0
e srli   00000088 0030d693 d 1 0 1 0 8 0
e slli   0000008c 00109713 e 1 0 1 0 7 0

// ==== project.f ====
hdl/front_end_pkg.sv
hdl/fetch_if.sv
hdl/inst_decoder.sv
hdl/dispatch_stage.sv
hdl/imem_fetch_unit.sv
hdl/front_end_top.sv
testbench/tb_front_end.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_front_end
FILELIST  := project.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) testbench/front_end_tests.txt
	./$(BIN)

clean:
	rm -rf obj_dir
